// File: sources.f
common/issue_pkg.sv
hw/instr_decoder.sv
instruction_queue/instruction_queue.sv
hw/alu_execute.sv
hw/result_regfile.sv
hw/issue_core_top.sv
verif/tb_issue_core.sv

// File: Bender.yml
package:
  name: issue_core

sources:
  # Shared package first
  - common/issue_pkg.sv
  # Design
  - hw/instr_decoder.sv
  - instruction_queue/instruction_queue.sv
  - hw/alu_execute.sv
  - hw/result_regfile.sv
  - hw/issue_core_top.sv
  # Testbench
  - target: test
    files:
      - verif/tb_issue_core.sv

// File: verif/tb_issue_core.sv
// Issue slice testbench
module tb_issue_core;
    timeunit 1ns;
    timeprecision 100ps;

    import issue_pkg::*;

    localparam int unsigned NUM_ENTRIES = 8;
    localparam int unsigned NUM_RANDOM  = 300;
    localparam int unsigned MAX_WORDS   = NUM_RANDOM + 100;     // Directed words on top
    localparam int unsigned MAX_CYCLES  = MAX_WORDS * 4 + 200;  // Margin for drains and flushes

    logic        clk_i;
    logic        rstn_i;
    instr_word_t instr_i;
    logic        instr_valid_i;
    logic        flush_i;
    logic        stall_i;
    logic        full_o;
    logic        wb_valid_o;
    reg_addr_t   wb_rd_o;
    xlen_t       wb_data_o;

    integer      seed;
    int unsigned cycle_count;
    int unsigned accepted;       // Entries written into the queue
    instr_word_t expected_q[$];  // Accepted words still owed a writeback
    xlen_t       model_regs [32];
    instr_word_t wb_word;
    reg_addr_t   exp_rd;
    xlen_t       exp_data;

    issue_core_top #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_dut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .flush_i       (flush_i),
        .stall_i       (stall_i),
        .full_o        (full_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #50 clk_i = ~clk_i;  // 100 ns period

    // Instruction encoders
    function automatic instr_word_t r_type(input funct7_t f7, input funct3_t f3,
                                           input reg_addr_t rd, input reg_addr_t rs1,
                                           input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPCODE_OP};
    endfunction

    function automatic instr_word_t i_type(input funct3_t f3, input reg_addr_t rd,
                                           input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPCODE_OP_IMM};
    endfunction

    // Supported RV32I ALU forms
    function automatic logic ref_legal(input instr_word_t w);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        if (w[6:0] == OPCODE_OP) begin
            return (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
        end
        if (w[6:0] == OPCODE_OP_IMM) begin
            if (f3 == 3'b001) begin
                return f7 == 7'h00;  // SLLI
            end
            if (f3 == 3'b101) begin
                return f7 == 7'h00 || f7 == 7'h20;  // SRLI or SRAI
            end
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // Architectural result of a legal word
    function automatic xlen_t ref_compute(input instr_word_t w, input xlen_t a,
                                          input xlen_t r2);
        logic       imm_form;
        xlen_t      b;
        logic [4:0] sh;
        imm_form = (w[6:0] == OPCODE_OP_IMM);
        b        = imm_form ? {{20{w[31]}}, w[31:20]} : r2;
        sh       = b[4:0];  // Equals imm[4:0] for shift-immediates
        case (w[14:12])
            3'b000: return (!imm_form && w[30]) ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return xlen_t'($signed(a) < $signed(b));
            3'b011: return xlen_t'(a < b);  // SLTIU compares the sign-extended imm
            3'b100: return a ^ b;
            3'b101: begin
                if (w[30]) begin
                    return xlen_t'($signed(a) >>> sh);
                end
                return a >> sh;
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_rd(input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: wb_rd_o is x%0d, expected x%0d",
                                $time, got, exp));
        end
    endtask

    task automatic check_data(input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: wb_data_o is %h, expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Drive one word for the queue to sample at the following edge
    task automatic offer_word(input instr_word_t word, input logic valid, input logic stall);
        @(posedge clk_i);
        instr_i       <= word;
        instr_valid_i <= valid;
        stall_i       <= stall;
        @(negedge clk_i);
        if (valid && !full_o && ref_legal(word)) begin
            accepted++;
            if (word[11:7] != 5'd0) begin
                expected_q.push_back(word);  // x0 targets retire silently
            end
        end
    endtask

    task automatic send_word(input instr_word_t word);
        offer_word(word, 1'b1, 1'b0);
    endtask

    task automatic idle_cycles(input int unsigned n, input logic stall);
        repeat (n) begin
            @(posedge clk_i);
            instr_valid_i <= 1'b0;
            stall_i       <= stall;
        end
    endtask

    task automatic drain();
        idle_cycles(1, 1'b0);
        while (expected_q.size() != 0) begin
            idle_cycles(1, 1'b0);
        end
        idle_cycles(4, 1'b0);  // Let x0 targets leave the queue too
    endtask

    // Stall until execute is empty and flush what is queued
    task automatic flush_queue();
        idle_cycles(4, 1'b1);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        expected_q.delete();
    endtask

    // Registers x0..x7 only to make hazards frequent
    task automatic random_word(output instr_word_t word);
        logic [31:0] r;
        logic [31:0] s;
        funct7_t     f7;
        r  = $random(seed);
        s  = $random(seed);
        f7 = r[4] ? F7_ALT : F7_BASE;
        if (r[6:5] == 2'b11) begin
            f7 = s[31:25];  // Mostly illegal
        end
        case (r[2:0])
            3'd0: word = s;  // Arbitrary bits
            3'd1, 3'd2, 3'd3: begin
                word = r_type(f7, s[14:12], {2'b00, s[9:7]}, {2'b00, s[17:15]},
                              {2'b00, s[22:20]});
            end
            default: begin
                word = i_type(s[14:12], {2'b00, s[9:7]}, {2'b00, s[17:15]}, {f7, s[24:20]});
            end
        endcase
    endtask

    // Compare each writeback against the oldest accepted word
    always @(negedge clk_i) begin
        if (rstn_i && wb_valid_o) begin
            if (expected_q.size() == 0) begin
                abort_run($sformatf("Writeback to x%0d at %0t with no instruction pending",
                                    wb_rd_o, $time));
            end else begin
                wb_word  = expected_q.pop_front();
                exp_rd   = wb_word[11:7];
                exp_data = ref_compute(wb_word, model_regs[wb_word[19:15]],
                                       model_regs[wb_word[24:20]]);
                check_rd(wb_rd_o, exp_rd);
                check_data(wb_data_o, exp_data);
                model_regs[exp_rd] = exp_data;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            abort_run($sformatf("Timeout after %0d clock cycles", cycle_count));
        end
    end

    initial begin
        int unsigned fill_start;
        logic [31:0] r;
        instr_word_t word;
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        flush_i       = 1'b0;
        stall_i       = 1'b0;
        seed          = 32'h9e54;
        cycle_count   = 0;
        accepted      = 0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        check_flag(full_o, 1'b1, "full_o in reset");
        rstn_i <= 1'b1;

        // Every supported instruction
        send_word(i_type(F3_ADD_SUB, 5'd1, 5'd0, 12'd100));
        send_word(i_type(F3_ADD_SUB, 5'd2, 5'd0, 12'hff9));  // -7
        send_word(i_type(F3_ADD_SUB, 5'd3, 5'd0, 12'h7ff));
        send_word(i_type(F3_ADD_SUB, 5'd4, 5'd0, 12'h800));  // -2048
        send_word(r_type(F7_BASE, F3_ADD_SUB, 5'd5, 5'd1, 5'd2));
        send_word(r_type(F7_ALT, F3_ADD_SUB, 5'd6, 5'd2, 5'd1));
        send_word(r_type(F7_BASE, F3_SLL, 5'd7, 5'd1, 5'd2));
        send_word(r_type(F7_BASE, F3_SLT, 5'd8, 5'd2, 5'd1));
        send_word(r_type(F7_BASE, F3_SLTU, 5'd9, 5'd2, 5'd1));
        send_word(r_type(F7_BASE, F3_XOR, 5'd10, 5'd1, 5'd2));
        send_word(r_type(F7_BASE, F3_SRL_SRA, 5'd11, 5'd2, 5'd1));
        send_word(r_type(F7_ALT, F3_SRL_SRA, 5'd12, 5'd2, 5'd1));
        send_word(r_type(F7_BASE, F3_OR, 5'd13, 5'd3, 5'd4));
        send_word(r_type(F7_BASE, F3_AND, 5'd14, 5'd2, 5'd3));
        send_word(i_type(F3_SLT, 5'd15, 5'd2, 12'hfff));
        send_word(i_type(F3_SLTU, 5'd16, 5'd1, 12'hfff));
        send_word(i_type(F3_XOR, 5'd17, 5'd2, 12'hfff));
        send_word(i_type(F3_OR, 5'd18, 5'd1, 12'h0f0));
        send_word(i_type(F3_AND, 5'd19, 5'd2, 12'h0ff));
        send_word(i_type(F3_SLL, 5'd20, 5'd2, 12'h01f));
        send_word(i_type(F3_SRL_SRA, 5'd21, 5'd2, 12'h003));
        send_word(i_type(F3_SRL_SRA, 5'd22, 5'd4, 12'h405));  // SRAI by 5
        drain();

        // Each word reads the previous rd
        send_word(i_type(F3_ADD_SUB, 5'd1, 5'd1, 12'd1));
        send_word(r_type(F7_BASE, F3_ADD_SUB, 5'd2, 5'd1, 5'd1));
        send_word(r_type(F7_ALT, F3_ADD_SUB, 5'd3, 5'd2, 5'd6));
        send_word(r_type(F7_BASE, F3_XOR, 5'd1, 5'd3, 5'd2));
        send_word(r_type(F7_BASE, F3_SLL, 5'd4, 5'd1, 5'd1));
        send_word(i_type(F3_SRL_SRA, 5'd4, 5'd4, 12'h402));
        send_word(r_type(F7_BASE, F3_SLT, 5'd5, 5'd4, 5'd3));
        drain();

        // Words that never write back
        send_word(32'h12345037);                                 // LUI
        send_word(32'h0000a083);                                 // Load
        send_word(r_type(7'h01, F3_ADD_SUB, 5'd1, 5'd2, 5'd3));  // MUL
        send_word(r_type(F7_ALT, F3_XOR, 5'd1, 5'd2, 5'd3));
        send_word(i_type(F3_SLL, 5'd1, 5'd2, 12'h401));
        send_word(i_type(F3_SRL_SRA, 5'd1, 5'd2, 12'h201));
        send_word(i_type(F3_ADD_SUB, 5'd0, 5'd2, 12'd5));        // x0 target
        offer_word(i_type(F3_ADD_SUB, 5'd1, 5'd0, 12'd999), 1'b0, 1'b0);
        send_word(r_type(F7_BASE, F3_OR, 5'd23, 5'd1, 5'd0));    // x1 still intact
        drain();

        // Back-pressure fills the queue
        fill_start = accepted;
        check_flag(full_o, 1'b0, "full_o before stall");
        for (int i = 0; i < NUM_ENTRIES + 3; i++) begin
            offer_word(i_type(F3_ADD_SUB, reg_addr_t'(24 + i % 4), reg_addr_t'(24 + i % 4),
                              12'(i + 1)), 1'b1, 1'b1);
        end
        check_flag(full_o, 1'b1, "full_o under stall");
        if (accepted - fill_start != NUM_ENTRIES) begin
            abort_run($sformatf("Queue took %0d words under stall instead of %0d",
                                accepted - fill_start, NUM_ENTRIES));
        end
        drain();

        // Flushed words leave the registers alone
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            offer_word(i_type(F3_ADD_SUB, reg_addr_t'(24 + i % 4), 5'd0, 12'h555), 1'b1, 1'b1);
        end
        flush_queue();
        idle_cycles(1, 1'b0);
        send_word(r_type(F7_BASE, F3_ADD_SUB, 5'd28, 5'd24, 5'd25));
        send_word(r_type(F7_BASE, F3_OR, 5'd29, 5'd26, 5'd27));
        drain();

        // Random mix with stalls and flushes
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            if (r[5:0] == 6'd0) begin
                flush_queue();
            end
            random_word(word);
            offer_word(word, r[7:6] != 2'b00, r[9:8] == 2'b00);
        end
        drain();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: hw/issue_core_top.sv
// Integer issue slice top level
module issue_core_top #(
    parameter int unsigned NUM_ENTRIES = issue_pkg::IQ_DEFAULT_ENTRIES  // Queue depth
) (
    input  logic                   clk_i,          // Clock
    input  logic                   rstn_i,         // Async reset, active low
    input  issue_pkg::instr_word_t instr_i,        // Instruction word
    input  logic                   instr_valid_i,  // Word present
    input  logic                   flush_i,        // Flush queue and execute
    input  logic                   stall_i,        // Stop popping the queue
    output logic                   full_o,         // Queue full
    output logic                   wb_valid_o,     // Writeback this cycle
    output issue_pkg::reg_addr_t   wb_rd_o,
    output issue_pkg::xlen_t       wb_data_o
);
    import issue_pkg::*;

    instr_entry_t dec_entry;   // Decoder to queue
    instr_entry_t head_entry;  // Queue head to execute
    logic         iq_empty;
    logic         pop;
    reg_addr_t    rs1_addr;
    reg_addr_t    rs2_addr;
    xlen_t        rs1_data;
    xlen_t        rs2_data;
    exe_result_t  exe_result;

    instr_decoder u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .entry_o       (dec_entry)
    );

    instruction_queue #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_queue (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instruction_i (dec_entry),
        .flush_i       (flush_i),
        .read_head_i   (pop),
        .instruction_o (head_entry),
        .full_o        (full_o),
        .empty_o       (iq_empty)
    );

    alu_execute u_execute (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .head_i      (head_entry),
        .empty_i     (iq_empty),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .read_head_o (pop),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .result_o    (exe_result)
    );

    result_regfile u_regfile (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .result_i   (exe_result),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // Writeback ports
    assign wb_valid_o = exe_result.valid;
    assign wb_rd_o    = exe_result.rd;
    assign wb_data_o  = exe_result.data;

endmodule

// File: hw/result_regfile.sv
// Integer register file
module result_regfile (
    input  logic                   clk_i,       // Clock
    input  logic                   rstn_i,      // Async reset, active low
    input  issue_pkg::exe_result_t result_i,    // Registered execute result
    input  issue_pkg::reg_addr_t   rs1_addr_i,
    input  issue_pkg::reg_addr_t   rs2_addr_i,
    output issue_pkg::xlen_t       rs1_data_o,
    output issue_pkg::xlen_t       rs2_data_o
);
    import issue_pkg::*;

    localparam int unsigned NUM_REGS = 32;

    // x1..x31, x0 has no storage
    xlen_t regs_q [1:NUM_REGS-1];

    logic write_en;

    assign write_en = result_i.valid && (result_i.rd != '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;  // Architectural state starts at zero
            end
        end else if (write_en) begin
            regs_q[result_i.rd] <= result_i.data;
        end
    end

    // Combinational reads, no internal bypass
    // A same-cycle write is covered by forwarding in execute
    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;  // Hardwired zero
        end else begin
            rs1_data_o = regs_q[rs1_addr_i];
        end
    end

    always_comb begin
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end else begin
            rs2_data_o = regs_q[rs2_addr_i];
        end
    end

endmodule

// File: hw/alu_execute.sv
// Integer execute stage
module alu_execute (
    input  logic                    clk_i,        // Clock
    input  logic                    rstn_i,       // Async reset, active low
    input  issue_pkg::instr_entry_t head_i,       // Queue head entry
    input  logic                    empty_i,      // Queue has nothing to pop
    input  logic                    stall_i,      // Hold issue
    input  logic                    flush_i,      // Kill in-flight work
    input  issue_pkg::xlen_t        rs1_data_i,   // Register file read port 1
    input  issue_pkg::xlen_t        rs2_data_i,   // Register file read port 2
    output logic                    read_head_o,  // Pop pulse to the queue
    output issue_pkg::reg_addr_t    rs1_addr_o,
    output issue_pkg::reg_addr_t    rs2_addr_o,
    output issue_pkg::exe_result_t  result_o      // Registered ALU result
);
    import issue_pkg::*;

    instr_entry_t op_q;        // Entry taken at the pop edge
    logic         op_valid_q;
    logic         res_valid_q;
    reg_addr_t    res_rd_q;
    xlen_t        res_data_q;
    xlen_t        opa;         // First operand after forwarding
    xlen_t        rs2_val;     // Second register after forwarding
    xlen_t        opb;         // Second operand, register or immediate
    logic [4:0]   shamt;
    xlen_t        alu_res;
    logic         fwd_rs1;
    logic         fwd_rs2;

    assign read_head_o = ~stall_i & ~empty_i;

    // Issue register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            op_valid_q <= 1'b0;
        end else if (flush_i) begin
            op_valid_q <= 1'b0;
        end else begin
            op_valid_q <= read_head_o & head_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_head_o) begin
            op_q <= head_i;  // Payload only
        end
    end

    // Operand read, previous result is not in the register file yet
    assign rs1_addr_o = op_q.rs1;
    assign rs2_addr_o = op_q.rs2;
    assign fwd_rs1    = res_valid_q && (res_rd_q != '0) && (res_rd_q == op_q.rs1);
    assign fwd_rs2    = res_valid_q && (res_rd_q != '0) && (res_rd_q == op_q.rs2);
    assign opa        = fwd_rs1 ? res_data_q : rs1_data_i;
    assign rs2_val    = fwd_rs2 ? res_data_q : rs2_data_i;
    assign opb        = op_q.use_imm ? op_q.imm : rs2_val;
    assign shamt      = opb[4:0];

    always_comb begin
        case (op_q.alu_op)
            ALU_ADD:  alu_res = opa + opb;
            ALU_SUB:  alu_res = opa - opb;
            ALU_SLL:  alu_res = opa << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, opa < opb};
            ALU_XOR:  alu_res = opa ^ opb;
            ALU_SRL:  alu_res = opa >> shamt;
            ALU_SRA:  alu_res = xlen_t'($signed(opa) >>> shamt);
            ALU_OR:   alu_res = opa | opb;
            ALU_AND:  alu_res = opa & opb;
            default:  alu_res = '0;
        endcase
    end

    // Result register, x0 targets never write back
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= op_valid_q & (op_q.rd != '0);
        end
    end

    always_ff @(posedge clk_i) begin
        res_rd_q   <= op_q.rd;
        res_data_q <= alu_res;
    end

    assign result_o = '{valid: res_valid_q, rd: res_rd_q, data: res_data_q};

endmodule

// File: instruction_queue/instruction_queue.sv
// Circular instruction queue
module instruction_queue #(
    parameter int unsigned NUM_ENTRIES
) (
    input  logic                    clk_i,          // Clock
    input  logic                    rstn_i,         // Async reset, active low
    input  issue_pkg::instr_entry_t instruction_i,  // Decoded entry to push
    input  logic                    flush_i,        // Drop every stored entry
    input  logic                    read_head_i,    // Pop the head
    output issue_pkg::instr_entry_t instruction_o,  // Head entry, zero when empty
    output logic                    full_o,         // No free slot
    output logic                    empty_o         // Nothing stored
);
    import issue_pkg::*;

    localparam int unsigned PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;  // One bit wider than the pointers

    localparam count_t MAX_COUNT = count_t'(NUM_ENTRIES);

    instr_entry_t buffer_q [NUM_ENTRIES];  // Entry storage

    ptr_t   head_q;   // Oldest entry
    ptr_t   tail_q;   // Next free slot
    count_t count_q;  // Occupancy
    logic   write_en;
    logic   read_en;

    // Wrap explicitly so any depth works
    function automatic ptr_t ptr_next(input ptr_t ptr);
        ptr_next = (ptr == ptr_t'(NUM_ENTRIES - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    // Push only real entries with room left; a word offered while full is lost
    assign write_en = instruction_i.valid & (count_q < MAX_COUNT);
    assign read_en  = read_head_i & (count_q != '0);

    // Storage
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            buffer_q[tail_q] <= instruction_i;
        end
    end

    // Pointers and count, flush wins over push and pop
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (read_en) begin
                head_q <= ptr_next(head_q);
            end
            if (write_en) begin
                tail_q <= ptr_next(tail_q);
            end
            count_q <= count_q + count_t'(write_en) - count_t'(read_en);
        end
    end

    assign empty_o       = (count_q == '0);
    assign full_o        = (count_q == MAX_COUNT) | ~rstn_i;  // Held full during reset
    assign instruction_o = empty_o ? '0 : buffer_q[head_q];

endmodule

// File: hw/instr_decoder.sv
// RV32I ALU group decoder
module instr_decoder (
    input  issue_pkg::instr_word_t  instr_i,        // Raw instruction word
    input  logic                    instr_valid_i,  // Word present this cycle
    output issue_pkg::instr_entry_t entry_o         // Decoded entry for the queue
);
    import issue_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    xlen_t     imm_i_type;   // Sign-extended I-type immediate
    xlen_t     shamt;        // Zero-extended shift amount
    logic      legal;        // Matches a supported form
    alu_op_t   alu_op;
    logic      use_imm;
    xlen_t     imm;

    // Field extraction
    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign shamt      = {{(XLEN-5){1'b0}}, instr_i[24:20]};

    always_comb begin
        legal   = 1'b0;
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        imm     = '0;
        case (opcode)
            OPCODE_OP: begin
                // Only SUB and SRA may use the alternate funct7
                legal = (funct7 == F7_BASE) ||
                        ((funct7 == F7_ALT) && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
                case (funct3)
                    F3_ADD_SUB: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    default:    alu_op = ALU_AND;
                endcase
            end
            OPCODE_OP_IMM: begin
                use_imm = 1'b1;
                legal   = 1'b1;  // Narrowed below for shifts
                imm     = imm_i_type;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;  // No SUBI in RV32I
                    F3_SLL: begin
                        alu_op = ALU_SLL;
                        imm    = shamt;
                        legal  = (funct7 == F7_BASE);
                    end
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;  // Immediate still sign-extended
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: begin
                        alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        imm    = shamt;
                        legal  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    F3_OR:      alu_op = ALU_OR;
                    default:    alu_op = ALU_AND;
                endcase
            end
            default: legal = 1'b0;  // Everything else is dropped
        endcase
    end

    // Pack the entry
    always_comb begin
        entry_o         = '0;
        entry_o.valid   = instr_valid_i & legal;
        entry_o.alu_op  = alu_op;
        entry_o.rd      = instr_i[11:7];
        entry_o.rs1     = instr_i[19:15];
        entry_o.rs2     = use_imm ? '0 : instr_i[24:20];  // Immediate forms read one source
        entry_o.use_imm = use_imm;
        entry_o.imm     = imm;
    end

endmodule

// File: common/issue_pkg.sv
// Issue slice shared definitions
package issue_pkg;

    // Data path width
    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;        // Operand and result data
    typedef logic [4:0]      reg_addr_t;    // Architectural register index
    typedef logic [31:0]     instr_word_t;  // Raw RV32I instruction word
    typedef logic [3:0]      alu_op_t;      // Internal ALU operation code
    typedef logic [6:0]      opcode_t;      // Major opcode field
    typedef logic [2:0]      funct3_t;      // Minor opcode field
    typedef logic [6:0]      funct7_t;      // Upper function field

    // Accepted major opcodes
    localparam opcode_t OPCODE_OP     = 7'b0110011;  // Register-register ALU
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;  // Register-immediate ALU

    // funct3 encodings shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 values, ALT selects SUB and arithmetic shift
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // ALU operations
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // Default instruction queue depth
    localparam int unsigned IQ_DEFAULT_ENTRIES = 8;

    // Decoded instruction as stored in the queue
    typedef struct packed {
        logic      valid;    // Supported instruction
        alu_op_t   alu_op;   // Operation to perform
        reg_addr_t rd;       // Destination register
        reg_addr_t rs1;      // First source
        reg_addr_t rs2;      // Second source, unused with immediate
        logic      use_imm;  // Second operand comes from imm
        xlen_t     imm;      // Sign-extended immediate or shift amount
    } instr_entry_t;

    // Registered execute result
    typedef struct packed {
        logic      valid;    // Writeback pending, never set for x0
        reg_addr_t rd;       // Destination register
        xlen_t     data;     // ALU result
    } exe_result_t;

endpackage
